// ==== files.f ====
verilog/riscv_isa_pkg.sv
verilog/core_bus_pkg.sv
verilog/instr_fetch.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/int_alu.sv
verilog/exec_core.sv
test/wb_instr_mem.sv
test/tb_exec_core.sv

// ==== Makefile ====
# Verilator build and run for the execute core testbench

TOP = tb_exec_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f files.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir

// ==== test/tb_exec_core.sv ====
// Testbench for exec_core: random OP/OP-IMM program, reference register model, bus checks
`default_nettype none

module tb_exec_core import riscv_isa_pkg::*, core_bus_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PROBE_OPS = 16;
	localparam int SEED_OPS  = PROBE_OPS + 31 + 8 * 3 + 2;
	localparam int PROG_LEN  = SEED_OPS + 100;

	logic              clk;
	logic              rst;
	logic              wb_ack;
	logic [XLEN-1:0]   wb_dat;
	logic              wb_cyc;
	logic              wb_stb;
	logic [ADDR_W-1:0] wb_adr;
	logic              retire_valid;
	logic [ADDR_W-1:0] retire_pc;
	logic [REG_IDX_W-1:0] retire_rd;
	logic [XLEN-1:0]   retire_data;
	logic              bad_addr;

	logic [XLEN-1:0]      model_regs [REG_COUNT];
	logic [ADDR_W-1:0]    exp_pc;     // Address of the next fetch
	logic                 exp_retire;
	logic [ADDR_W-1:0]    exp_rpc;
	logic [REG_IDX_W-1:0] exp_rd;
	logic [XLEN-1:0]      exp_data;
	int                   fetch_count;
	int                   retire_count;
	int                   errors;
	bit                   timed_out;
	integer               seed = 64;

	exec_core exec_core_inst (
		.clk, .rst, .wb_ack, .wb_dat,
		.wb_cyc, .wb_stb, .wb_adr,
		.retire_valid, .retire_pc, .retire_rd, .retire_data
	);

	wb_instr_mem imem_inst (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_adr, .wb_dat, .wb_ack, .bad_addr
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] make_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		instr_u w;
		w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP_REG};
		return w;
	endfunction

	function automatic logic [31:0] make_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd);
		instr_u w;
		w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OP_IMM};
		return w;
	endfunction

	// RV32I semantics of OP and OP-IMM, funct7 bit 30 picks SUB and SRA
	function automatic logic [31:0] ref_result(instr_u w, logic [31:0] a, logic [31:0] rs2v);
		logic [31:0] b;
		logic        alt;
		if (w.r.opcode == OP_IMM) begin
			b   = {{20{w.i.imm12[11]}}, w.i.imm12};
			alt = (w.i.funct3 == 3'd5) && w.i.imm12[10];
		end else begin
			b   = rs2v;
			alt = (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5) && w.r.funct7[5];
		end
		case (w.r.funct3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic build_program();
		int          n;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [31:0] r;
		imem_inst.fill_pattern();
		n = 0;
		// Every register read before it is written, stale contents show after a restart
		for (int j = 1; j <= PROBE_OPS; j++) begin
			imem_inst.words[n] = make_r(7'b0, 5'(2 * j), 5'(2 * j - 1), 3'd6, 5'd0); // OR x0
			n++;
		end
		for (int k = 1; k < 32; k++) begin
			imem_inst.words[n] = make_i(12'($random(seed)), 5'd0, 3'd0, 5'(k)); // ADDI
			n++;
		end
		for (int k = 1; k < 9; k++) begin // Large and negative values
			imem_inst.words[n] = make_i(12'(k * 3 + 9), 5'(k), 3'd1, 5'(k));
			imem_inst.words[n + 1] = make_i(12'($random(seed)), 5'(k), 3'd6, 5'(k));
			imem_inst.words[n + 2] = make_i(12'(k + 4), 5'(k), 3'd1, 5'(k));
			n += 3;
		end
		imem_inst.words[n] = make_i(12'h7ff, 5'd1, 3'd0, 5'd0); // Nonzero result into x0
		imem_inst.words[n + 1] = make_r(7'b0, 5'd0, 5'd0, 3'd0, 5'd0); // x0 + x0
		n += 2;
		while (n < PROG_LEN) begin
			r  = $random(seed);
			f3 = r[2:0];
			if (r[6:4] == 3'd7) begin
				imem_inst.words[n] = {r[31:7], 7'b0000011}; // Load, skipped
			end else if (r[3]) begin
				imem_inst.words[n] = make_r((f3 == 0 || f3 == 5) ? {1'b0, r[7], 5'b0} : 7'b0,
					r[12:8], r[17:13], f3, r[22:18]);
			end else begin
				imm = r[31:20];
				if (f3 == 3'd1)
					imm = {7'b0, r[24:20]};
				else if (f3 == 3'd5)
					imm = {1'b0, r[7], 5'b0, r[24:20]}; // SRLI or SRAI
				imem_inst.words[n] = make_i(imm, r[17:13], f3, r[22:18]);
			end
			n++;
		end
	endtask

	// Reference model, advanced on every acked fetch
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++)
				model_regs[i] <= '0;
			exp_pc       <= RESET_PC;
			exp_retire   <= 1'b0;
			fetch_count  <= 0;
			retire_count <= 0;
		end else begin
			exp_retire <= 1'b0;
			if (wb_cyc && wb_stb && wb_ack) begin
				exp_pc      <= exp_pc + 4;
				fetch_count <= fetch_count + 1;
				if (wb_dat[6:0] == OP_REG || wb_dat[6:0] == OP_IMM) begin
					exp_retire <= 1'b1;
					exp_rpc    <= exp_pc;
					exp_rd     <= wb_dat[11:7];
					exp_data   <= ref_result(wb_dat, model_regs[wb_dat[19:15]],
						model_regs[wb_dat[24:20]]);
					if (wb_dat[11:7] != 0)
						model_regs[wb_dat[11:7]] <= ref_result(wb_dat,
							model_regs[wb_dat[19:15]], model_regs[wb_dat[24:20]]);
				end
			end
			if (retire_valid)
				retire_count <= retire_count + 1;
		end
	end

	idle_after_reset: assert property (@(posedge clk) rst |=> !wb_cyc && !retire_valid)
		else begin
			errors++;
			$display("FAILED %0t wb_cyc/retire_valid exp=0/0 got=%b/%b", $time,
				$sampled(wb_cyc), $sampled(retire_valid));
		end

	cyc_stb_equal: assert property (@(posedge clk) disable iff (rst) wb_cyc == wb_stb)
		else begin
			errors++;
			$display("FAILED %0t wb_stb exp=%b got=%b", $time, $sampled(wb_cyc),
				$sampled(wb_stb));
		end

	hold_until_ack: assert property (@(posedge clk) disable iff (rst)
			wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
		else begin
			errors++;
			$display("Bus request changed before ack at %0t", $time);
		end

	fetch_address: assert property (@(posedge clk) disable iff (rst)
			wb_cyc && wb_ack |-> wb_adr == exp_pc)
		else begin
			errors++;
			$display("FAILED %0t wb_adr exp=%h got=%h", $time, $sampled(exp_pc),
				$sampled(wb_adr));
		end

	in_range: assert property (@(posedge clk) disable iff (rst) !bad_addr)
		else begin
			errors++;
			$display("Fetch outside instruction memory at %0t", $time);
		end

	retire_timing: assert property (@(posedge clk) disable iff (rst)
			retire_valid == exp_retire)
		else begin
			errors++;
			$display("FAILED %0t retire_valid exp=%b got=%b", $time, $sampled(exp_retire),
				$sampled(retire_valid));
		end

	retire_fields: assert property (@(posedge clk) disable iff (rst)
			exp_retire |-> retire_rd == exp_rd && retire_pc == exp_rpc)
		else begin
			errors++;
			$display("FAILED %0t retire_rd/pc exp=%0d/%h got=%0d/%h", $time, $sampled(exp_rd),
				$sampled(exp_rpc), $sampled(retire_rd), $sampled(retire_pc));
		end

	retire_value: assert property (@(posedge clk) disable iff (rst)
			exp_retire |-> retire_data == exp_data)
		else begin
			errors++;
			$display("FAILED %0t retire_data exp=%h got=%h", $time, $sampled(exp_data),
				$sampled(retire_data));
		end

	task automatic wait_fetches(input int target);
		int cycles;
		cycles = 0;
		while (fetch_count < target && cycles < 4000) begin
			@(posedge clk);
			cycles++;
		end
		if (fetch_count < target)
			timed_out = 1'b1;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	initial begin
		rst       = 1'b1;
		errors    = 0;
		timed_out = 1'b0;
		build_program();
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		wait_fetches(SEED_OPS + 30);
		if (!timed_out) begin
			@(posedge clk);
			#1 apply_reset(); // Mid-program, registers and PC restart
			wait_fetches(PROG_LEN);
		end
		repeat (3) @(posedge clk);
		if (timed_out)
			$display("Timed out waiting for instruction fetches");
		$display("Errors: %0d, retires since last reset: %0d, fetches since last reset: %0d",
			errors, retire_count, fetch_count);
		if (errors == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule : tb_exec_core

`default_nettype wire

// ==== test/wb_instr_mem.sv ====
// Wishbone classic read-only instruction memory for the testbench, acks after a random wait
`default_nettype none

module wb_instr_mem import core_bus_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              wb_cyc,
	input  wire logic              wb_stb,
	input  wire logic [ADDR_W-1:0] wb_adr,
	output logic      [XLEN-1:0]   wb_dat,
	output logic                   wb_ack,
	output logic                   bad_addr
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 256;

	logic [XLEN-1:0]   words [MEM_WORDS];
	logic [ADDR_W-1:0] offset;
	logic              busy;       // Delay chosen for the open cycle
	int                wait_left;
	integer            seed = 64;

	assign offset   = wb_adr - RESET_PC;
	assign bad_addr = wb_cyc && wb_stb && (wb_adr < RESET_PC || (offset >> 2) >= MEM_WORDS);

	// Unused words get a skipped opcode, contents vary with every address bit
	task automatic fill_pattern();
		logic [ADDR_W-1:0] a;
		for (int i = 0; i < MEM_WORDS; i++) begin
			a = RESET_PC + ADDR_W'(i * INSTR_BYTES);
			words[i] = (a ^ {a[6:0], a[31:7]}) & 32'hFFFF_FF80;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			wb_ack    <= 1'b0;
			busy      <= 1'b0;
			wait_left <= 0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0; // Master drops cyc at this edge
			busy   <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy      <= 1'b1;
				wait_left <= $random(seed) & 3;
			end else if (wait_left == 0) begin
				wb_ack <= 1'b1;
				wb_dat <= bad_addr ? '0 : words[offset[9:2]];
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

endmodule : wb_instr_mem

`default_nettype wire

// ==== verilog/exec_core.sv ====
// Top of the single-issue execute core, fetch over Wishbone classic and report each writeback
`default_nettype none

module exec_core import riscv_isa_pkg::*, core_bus_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 wb_ack,
	input  wire logic [XLEN-1:0]      wb_dat,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic      [ADDR_W-1:0]    wb_adr,
	output logic                      retire_valid,
	output logic      [ADDR_W-1:0]    retire_pc,
	output logic      [REG_IDX_W-1:0] retire_rd,
	output logic      [XLEN-1:0]      retire_data
);

	logic [XLEN-1:0]      instr;
	logic                 instr_valid;
	logic [ADDR_W-1:0]    pc;
	logic [REG_IDX_W-1:0] rs1_idx;
	logic [REG_IDX_W-1:0] rs2_idx;
	logic [REG_IDX_W-1:0] rd_idx;
	alu_func_e            alu_func;
	logic [XLEN-1:0]      imm;
	logic                 use_imm;
	logic                 rd_we; // Already qualified by instr_valid
	logic [XLEN-1:0]      rs1_data;
	logic [XLEN-1:0]      rs2_data;
	logic [XLEN-1:0]      op_b;
	logic [XLEN-1:0]      result;

	instr_fetch fetch_inst (
		.clk, .rst, .wb_ack, .wb_dat,
		.wb_cyc, .wb_stb, .wb_adr,
		.instr, .instr_valid, .pc
	);

	instr_decode decode_inst (
		.instr, .instr_valid,
		.rs1_idx, .rs2_idx, .rd_idx,
		.alu_func, .imm, .use_imm,
		.wr_en (rd_we)
	);

	reg_file regs_inst (
		.clk, .rst,
		.rs1_idx, .rs2_idx, .rd_idx,
		.rd_data (result),
		.rd_we,
		.rs1_data, .rs2_data
	);

	assign op_b = use_imm ? imm : rs2_data; // Immediate or second source

	int_alu alu_inst (
		.op_a (rs1_data),
		.op_b,
		.alu_func,
		.result
	);

	// Retire in the same cycle as the write, x0 included
	assign retire_valid = rd_we;
	assign retire_pc    = pc;
	assign retire_rd    = rd_idx;
	assign retire_data  = result;

endmodule : exec_core

`default_nettype wire

// ==== verilog/int_alu.sv ====
// Combinational integer ALU covering the RV32I register and immediate arithmetic functions
`default_nettype none

module int_alu import riscv_isa_pkg::*, core_bus_pkg::*; (
	input  wire logic [XLEN-1:0] op_a,
	input  wire logic [XLEN-1:0] op_b,
	input  wire alu_func_e       alu_func,
	output logic      [XLEN-1:0] result
);

	logic [SHAMT_W-1:0] shamt;
	logic               lt_signed;
	logic               lt_unsigned;

	assign shamt       = op_b[SHAMT_W-1:0]; // Only the low bits count
	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		case (alu_func)
			ALU_ADD:  result = op_a + op_b;
			ALU_SUB:  result = op_a - op_b;
			ALU_SLL:  result = op_a << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:  result = op_a ^ op_b;
			ALU_SRL:  result = op_a >> shamt;
			ALU_SRA:  result = $signed(op_a) >>> shamt; // Sign fill
			ALU_OR:   result = op_a | op_b;
			ALU_AND:  result = op_a & op_b;
			default:  result = '0;
		endcase
	end

endmodule : int_alu

`default_nettype wire

// ==== verilog/reg_file.sv ====
// 32 x 32 integer register file, two combinational reads and one clocked write, x0 reads zero
`default_nettype none

module reg_file import riscv_isa_pkg::*, core_bus_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic [REG_IDX_W-1:0] rs1_idx,
	input  wire logic [REG_IDX_W-1:0] rs2_idx,
	input  wire logic [REG_IDX_W-1:0] rd_idx,
	input  wire logic [XLEN-1:0]      rd_data,
	input  wire logic                 rd_we,
	output logic      [XLEN-1:0]      rs1_data,
	output logic      [XLEN-1:0]      rs2_data
);

	logic [XLEN-1:0] regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (rd_we && rd_idx != '0) begin
			regs[rd_idx] <= rd_data; // Writes to x0 dropped
		end
	end

	// Read ports
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule : reg_file

`default_nettype wire

// ==== verilog/instr_decode.sv ====
// Combinational decode of OP and OP-IMM words into ALU function, register indices and immediate
`default_nettype none

module instr_decode import riscv_isa_pkg::*, core_bus_pkg::*; (
	input  wire logic [XLEN-1:0]      instr,
	input  wire logic                 instr_valid,
	output logic      [REG_IDX_W-1:0] rs1_idx,
	output logic      [REG_IDX_W-1:0] rs2_idx,
	output logic      [REG_IDX_W-1:0] rd_idx,
	output alu_func_e                 alu_func,
	output logic      [XLEN-1:0]      imm,
	output logic                      use_imm,
	output logic                      wr_en
);

	instr_u word;
	logic   known_op; // OP or OP-IMM
	logic   alt_bit;  // funct7 bit 5 where it selects SUB or SRA
	logic   [2:0] funct3;

	assign word = instr;

	always_comb begin
		rs1_idx  = word.r.rs1;
		rs2_idx  = word.r.rs2;
		rd_idx   = word.r.rd;
		funct3   = word.r.funct3;
		imm      = {{(XLEN-12){word.i.imm12[11]}}, word.i.imm12}; // Sign extend
		use_imm  = 1'b0;
		known_op = 1'b0;
		alt_bit  = 1'b0;

		case (word.r.opcode)
			OP_REG: begin
				known_op = 1'b1;
				if (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)
					alt_bit = word.r.funct7[5];
			end
			OP_IMM: begin
				known_op = 1'b1;
				use_imm  = 1'b1;
				// No SUBI, only SRAI reads the upper immediate bit
				if (word.i.funct3 == F3_SRL_SRA)
					alt_bit = word.i.imm12[10];
			end
			default: begin
				known_op = 1'b0; // Skipped, no writeback
			end
		endcase

		alu_func = alu_func_e'({alt_bit, funct3});
	end

	// Only a word that is actually being executed writes back
	assign wr_en = instr_valid && known_op;

endmodule : instr_decode

`default_nettype wire

// ==== verilog/instr_fetch.sv ====
// Wishbone classic fetch master, one read per instruction, hands the word to decode
`default_nettype none

module instr_fetch import core_bus_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              wb_ack,
	input  wire logic [XLEN-1:0]   wb_dat,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	output logic      [ADDR_W-1:0] wb_adr,
	output logic      [XLEN-1:0]   instr,
	output logic                   instr_valid,
	output logic      [ADDR_W-1:0] pc
);

	typedef enum logic {
		FETCH,   // Bus cycle open, waiting for ack
		EXECUTE  // Word held for one cycle, also the idle state out of reset
	} fetch_state_e;

	fetch_state_e state;
	logic         cyc_stb; // cyc and stb always move together

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= EXECUTE;
			cyc_stb     <= 1'b0;
			instr_valid <= 1'b0;
			pc          <= RESET_PC;
		end else begin
			case (state)
				FETCH: begin
					if (wb_ack) begin
						cyc_stb     <= 1'b0;
						instr_valid <= 1'b1;
						state       <= EXECUTE;
					end
				end
				EXECUTE: begin
					// Step past the word just executed, none after reset
					if (instr_valid)
						pc <= pc + ADDR_W'(INSTR_BYTES);
					instr_valid <= 1'b0;
					cyc_stb     <= 1'b1;
					state       <= FETCH;
				end
				default: state <= EXECUTE;
			endcase
		end
	end

	// Instruction word, captured on ack
	always_ff @(posedge clk) begin
		if (state == FETCH && wb_ack)
			instr <= wb_dat;
	end

	assign wb_cyc = cyc_stb;
	assign wb_stb = cyc_stb;
	assign wb_adr = pc; // Stable for the whole bus cycle

endmodule : instr_fetch

`default_nettype wire

// ==== verilog/core_bus_pkg.sv ====
// Datapath and fetch bus constants, imported by the core modules and the testbench
`default_nettype none

package core_bus_pkg;

	// Data and address widths
	localparam int XLEN   = 32;
	localparam int ADDR_W = 32;

	// First fetch address after reset
	localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

	// PC step per instruction
	localparam int INSTR_BYTES = 4;

endpackage : core_bus_pkg

`default_nettype wire

// ==== verilog/riscv_isa_pkg.sv ====
// RV32I instruction set definitions shared by decode, ALU, register file and the testbench
`default_nettype none

package riscv_isa_pkg;

	// Register file geometry
	localparam int REG_COUNT = 32;
	localparam int REG_IDX_W = 5;
	localparam int SHAMT_W   = 5; // Shift amount width, low bits of op_b

	// funct3 groups where funct7 bit 5 selects the alternate function
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		OP_REG = 7'b0110011, // Register-register
		OP_IMM = 7'b0010011  // Register-immediate
	} opcode_e;

	// Encoded as {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} alu_func_e;

	// R-type field view
	typedef struct packed {
		logic [6:0]           funct7;
		logic [REG_IDX_W-1:0] rs2;
		logic [REG_IDX_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [REG_IDX_W-1:0] rd;
		logic [6:0]           opcode;
	} r_instr_t;

	// I-type field view
	typedef struct packed {
		logic [11:0]          imm12;
		logic [REG_IDX_W-1:0] rs1;
		logic [2:0]           funct3;
		logic [REG_IDX_W-1:0] rd;
		logic [6:0]           opcode;
	} i_instr_t;

	// Same 32-bit word, two decodings
	typedef union packed {
		r_instr_t r;
		i_instr_t i;
	} instr_u;

endpackage : riscv_isa_pkg

`default_nettype wire
